/* logic/fpga_pkg.sv */
// Board constants, port count, timer sizing, port status and port LED structs
package fpga_pkg;

// QSFP cages on the card
localparam int PORT_CNT = 2;

// Flip-flops in each input synchronizer
localparam int SYNC_STAGES = 3;

// Shared by the settle timer and the activity timers
localparam int TIMER_WIDTH = 5;

// Cycles the synchronized lock must hold before the core leaves reset
localparam logic [TIMER_WIDTH-1:0] LOCK_SETTLE_CYCLES = TIMER_WIDTH'(16);

// Cycles the activity LED stays lit after the last frame
localparam logic [TIMER_WIDTH-1:0] ACT_HOLD_CYCLES = TIMER_WIDTH'(8);

// Per-port link state, standing in for a MAC
typedef struct packed {
    // Level, link is up
    logic link_up;
    // Level, port fault
    logic fault;
    // One-cycle pulse per received frame
    logic rx_act;
    // One-cycle pulse per sent frame
    logic tx_act;
} port_status_t;

// Per-port front panel LEDs
typedef struct packed {
    // Activity, green blink
    logic act;
    // Link good
    logic stat_g;
    // Port fault
    logic stat_y;
} port_led_t;

endpackage

/* logic/cycle_timer.sv */
// Loadable down-counting timer with a busy flag while the count is nonzero
`resetall
`timescale 1ns/10ps

/*
 * Down counter
 *
 * A load takes priority over counting. The count stops at zero,
 * so one load gives exactly load_value busy cycles.
 */
module cycle_timer #(
    parameter int WIDTH = fpga_pkg::TIMER_WIDTH
) (
    input  logic             clk_125mhz,
    input  logic             arst_n,

    // Control from the owning block
    input  logic             load,
    input  logic [WIDTH-1:0] load_value,

    // High while cycles remain
    output logic             busy
);

logic [WIDTH-1:0] count;

always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        count <= '0;
    end else if (load) begin
        count <= load_value;
    end else if (count != '0) begin
        // Saturates at zero
        count <= count - 1'b1;
    end
end

// Straight from the counter register, no extra delay
assign busy = (count != '0);

endmodule

`resetall

/* logic/reset_supervisor.sv */
// Reset release and lock synchronizers, lock tracking FSM and core reset register
`resetall
`timescale 1ns/10ps

/*
 * Reset supervisor
 *
 * Holds the core in reset until the clock generator has reported lock
 * for LOCK_SETTLE_CYCLES cycles, and puts it back into reset as soon
 * as the synchronized lock drops.
 */
module reset_supervisor (
    input  logic clk_125mhz,
    input  logic arst_n,

    // Clock generator lock, asynchronous level
    input  logic mmcm_locked,

    // Synchronous active-high reset for the core
    output logic core_rst
);

typedef enum logic [1:0] {
    WAIT_LOCK = 2'd0,
    SETTLE    = 2'd1,
    RUN       = 2'd2
} state_t;

state_t state;
state_t state_next;

logic [fpga_pkg::SYNC_STAGES-1:0] rst_sync;
logic [fpga_pkg::SYNC_STAGES-1:0] lock_sync;
logic                             rst_sync_n;
logic                             lock_s;
logic                             settle_load;
logic                             settle_busy;

// Board reset asserts at once, release waits SYNC_STAGES edges
always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        rst_sync <= '0;
    end else begin
        rst_sync <= {rst_sync[fpga_pkg::SYNC_STAGES-2:0], 1'b1};
    end
end

assign rst_sync_n = rst_sync[fpga_pkg::SYNC_STAGES-1];

// Lock level into the clock domain
always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        lock_sync <= '0;
    end else begin
        lock_sync <= {lock_sync[fpga_pkg::SYNC_STAGES-2:0], mmcm_locked};
    end
end

assign lock_s = lock_sync[fpga_pkg::SYNC_STAGES-1];

always_comb begin
    state_next = state;
    case (state)
        WAIT_LOCK: begin
            // No start until the reset release has propagated
            if (lock_s && rst_sync_n) begin
                state_next = SETTLE;
            end
        end
        SETTLE: begin
            // Lock glitch restarts the whole wait
            if (!lock_s) begin
                state_next = WAIT_LOCK;
            end else if (!settle_busy) begin
                state_next = RUN;
            end
        end
        RUN: begin
            if (!lock_s) begin
                state_next = WAIT_LOCK;
            end
        end
        default: begin
            state_next = WAIT_LOCK;
        end
    endcase
end

// Timer is armed on the way into SETTLE
assign settle_load = (state == WAIT_LOCK) && (state_next == SETTLE);

cycle_timer #(
    .WIDTH(fpga_pkg::TIMER_WIDTH)
) settle_timer_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .load(settle_load),
    .load_value(fpga_pkg::LOCK_SETTLE_CYCLES),
    .busy(settle_busy)
);

// Release lags the RUN entry by a cycle, reassertion leaves RUN together
always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        state    <= WAIT_LOCK;
        core_rst <= 1'b1;
    end else begin
        state    <= state_next;
        core_rst <= !((state == RUN) && (state_next == RUN));
    end
end

endmodule

`resetall

/* logic/port_led_ctrl.sv */
// Per-port activity pulse stretcher and registered link and fault status LEDs
`resetall
`timescale 1ns/10ps

/*
 * Port LED controller
 *
 * act:    lit from the cycle after a frame pulse until ACT_HOLD_CYCLES
 *         cycles after the last one
 * stat_g: link up with no fault
 * stat_y: fault
 *
 * Everything is dark while the core is in reset.
 */
module port_led_ctrl (
    input  logic                   clk_125mhz,
    input  logic                   arst_n,

    // Synchronous core reset from the supervisor
    input  logic                   core_rst,

    // Link state and frame pulses of this port
    input  fpga_pkg::port_status_t status,

    // LED drive for this port
    output fpga_pkg::port_led_t    led
);

logic                             frame_pulse;
logic                             act_load;
logic [fpga_pkg::TIMER_WIDTH-1:0] act_load_value;
logic                             act_busy;
logic                             stat_g_q;
logic                             stat_y_q;

// Either direction counts as activity
assign frame_pulse = status.rx_act | status.tx_act;

// Core reset loads zero, which empties the hold timer
assign act_load       = core_rst | frame_pulse;
assign act_load_value = core_rst ? '0 : fpga_pkg::ACT_HOLD_CYCLES;

// Each pulse restarts the hold window
cycle_timer #(
    .WIDTH(fpga_pkg::TIMER_WIDTH)
) act_timer_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .load(act_load),
    .load_value(act_load_value),
    .busy(act_busy)
);

always_ff @(posedge clk_125mhz or negedge arst_n) begin
    if (!arst_n) begin
        stat_g_q <= 1'b0;
        stat_y_q <= 1'b0;
    end else if (core_rst) begin
        stat_g_q <= 1'b0;
        stat_y_q <= 1'b0;
    end else begin
        // A faulted port never shows green
        stat_g_q <= status.link_up & ~status.fault;
        stat_y_q <= status.fault;
    end
end

always_comb begin
    led.act    = act_busy;
    led.stat_g = stat_g_q;
    led.stat_y = stat_y_q;
end

endmodule

`resetall

/* logic/fpga.sv */
// Board top level with the reset supervisor and one LED controller per QSFP port
`resetall
`timescale 1ns/10ps

/*
 * FPGA top level
 *
 * Clock generator and transceivers sit outside this block. The 125 MHz
 * clock and the lock level arrive as plain inputs, and each port reports
 * its link state through a status struct.
 */
module fpga (
    // 125 MHz system clock
    input  logic                                            clk_125mhz,

    // Push button, active low
    input  logic                                            arst_n,

    // Clock generator lock
    input  logic                                            mmcm_locked,

    // Link state per port
    input  fpga_pkg::port_status_t [fpga_pkg::PORT_CNT-1:0] port_status,

    // Front panel LEDs
    output logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_act,
    output logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_g,
    output logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_y,

    // Reset for the rest of the design
    output logic                                            core_rst
);

fpga_pkg::port_led_t port_led [fpga_pkg::PORT_CNT];

reset_supervisor reset_supervisor_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .mmcm_locked(mmcm_locked),
    .core_rst(core_rst)
);

// One controller per cage
generate
    for (genvar i = 0; i < fpga_pkg::PORT_CNT; i++) begin : g_port
        port_led_ctrl port_led_ctrl_inst (
            .clk_125mhz(clk_125mhz),
            .arst_n(arst_n),
            .core_rst(core_rst),
            .status(port_status[i]),
            .led(port_led[i])
        );

        // Split the struct onto the LED pins
        assign qsfp_led_act[i]    = port_led[i].act;
        assign qsfp_led_stat_g[i] = port_led[i].stat_g;
        assign qsfp_led_stat_y[i] = port_led[i].stat_y;
    end
endgenerate

endmodule

`resetall

/* test/fpga_sva.sv */
// Bound assertions on the core reset against the supervisor state and lock loss
`timescale 1ns/10ps

module fpga_sva (
    input  logic clk_125mhz,
    input  logic arst_n,
    input  logic mmcm_locked,
    input  logic in_run,
    input  logic core_rst
);

// Core reset is held in every state but RUN
a_rst_outside_run: assert property (
    @(posedge clk_125mhz) disable iff (!arst_n)
    !in_run |-> core_rst
) else $error("core_rst is low while the supervisor is not in RUN");

// Core reset is up SYNC_STAGES + 2 cycles after the lock drops
a_rst_after_lock_loss: assert property (
    @(posedge clk_125mhz) disable iff (!arst_n)
    $fell(mmcm_locked) |-> ##(fpga_pkg::SYNC_STAGES + 2) core_rst
) else $error("core_rst did not rise in time after the lock dropped");

endmodule

bind reset_supervisor fpga_sva sva_inst (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .mmcm_locked(mmcm_locked),
    .in_run(state == RUN),
    .core_rst(core_rst)
);

/* test/fpga_checker.sv */
// Reference model of core reset and port LEDs with per-cycle and end-of-test checks
`timescale 1ns/10ps

module fpga_checker (
    input  logic                                            clk_125mhz,
    input  logic                                            arst_n,
    input  logic                                            mmcm_locked,
    input  fpga_pkg::port_status_t [fpga_pkg::PORT_CNT-1:0] port_status,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_act,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_g,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_y,
    input  logic                                            core_rst,

    // End of a test row and the LED levels expected there
    input  logic                                            test_done,
    input  int                                              test_idx,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   exp_act,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   exp_g,
    input  logic [fpga_pkg::PORT_CNT-1:0]                   exp_y,

    output int                                              pass_cnt,
    output int                                              fail_cnt
);

int                            hold [fpga_pkg::PORT_CNT];
logic [fpga_pkg::PORT_CNT-1:0] model_g;
logic [fpga_pkg::PORT_CNT-1:0] model_y;
int                            lock_hi;
int                            lock_lo;
logic                          core_rst_q;
int                            test_errs;

initial begin
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_errs = 0;
end

task automatic flag_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    test_errs++;
endtask

task automatic compare_leds(input string stage, input logic [fpga_pkg::PORT_CNT-1:0] act,
                            input logic [fpga_pkg::PORT_CNT-1:0] g,
                            input logic [fpga_pkg::PORT_CNT-1:0] y);
    if (qsfp_led_act !== act) begin
        flag_error($sformatf("%s act is %b, expected %b", stage, qsfp_led_act, act));
    end
    if (qsfp_led_stat_g !== g) begin
        flag_error($sformatf("%s stat_g is %b, expected %b", stage, qsfp_led_stat_g, g));
    end
    if (qsfp_led_stat_y !== y) begin
        flag_error($sformatf("%s stat_y is %b, expected %b", stage, qsfp_led_stat_y, y));
    end
endtask

// Samples see last cycle's inputs and the outputs they produced
always @(posedge clk_125mhz) begin
    logic [fpga_pkg::PORT_CNT-1:0] model_act;
    for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
        model_act[p] = (hold[p] != 0);
    end
    if (!arst_n) begin
        if (core_rst !== 1'b1) begin
            flag_error("core_rst is low during board reset");
        end
        compare_leds("reset", '0, '0, '0);
        for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
            hold[p] = 0;
        end
        model_g    = '0;
        model_y    = '0;
        lock_hi    = 0;
        lock_lo    = 0;
        core_rst_q = 1'b1;
    end else begin
        compare_leds("cycle", model_act, model_g, model_y);
        if (mmcm_locked) begin
            lock_hi++;
            lock_lo = 0;
        end else begin
            lock_lo++;
            lock_hi = 0;
        end
        // Release window after the lock rises
        if (core_rst_q && !core_rst && lock_hi <= int'(fpga_pkg::LOCK_SETTLE_CYCLES)) begin
            flag_error($sformatf("core_rst released after only %0d locked cycles", lock_hi));
        end
        if (core_rst && lock_hi > int'(fpga_pkg::LOCK_SETTLE_CYCLES) + fpga_pkg::SYNC_STAGES + 3)
        begin
            flag_error($sformatf("core_rst still high after %0d locked cycles", lock_hi));
        end
        if (!core_rst && lock_lo > fpga_pkg::SYNC_STAGES + 2) begin
            flag_error($sformatf("core_rst still low %0d cycles after lock loss", lock_lo));
        end
        core_rst_q = core_rst;
        for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
            if (core_rst) begin
                hold[p] = 0;
            end else if (port_status[p].rx_act || port_status[p].tx_act) begin
                hold[p] = int'(fpga_pkg::ACT_HOLD_CYCLES);
            end else if (hold[p] > 0) begin
                hold[p]--;
            end
            model_g[p] = !core_rst && port_status[p].link_up && !port_status[p].fault;
            model_y[p] = !core_rst && port_status[p].fault;
        end
    end
    if (test_done) begin
        compare_leds("end of test", exp_act, exp_g, exp_y);
        if (test_errs == 0) begin
            $display("Test %0d: pass", test_idx);
            pass_cnt++;
        end else begin
            $display("Test %0d: fail with %0d errors", test_idx, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    end
end

endmodule

/* test/tb_fpga.sv */
// Testbench top with clock, reset, stimulus table, watchdog and final verdict
`timescale 1ns/10ps

module tb_fpga;

typedef struct packed {
    logic [7:0]                    len;
    logic                          lock;
    logic [7:0]                    glitch_at;
    logic [fpga_pkg::PORT_CNT-1:0] link_up;
    logic [fpga_pkg::PORT_CNT-1:0] fault;
    logic [7:0]                    spacing;
    logic [fpga_pkg::PORT_CNT-1:0] exp_act;
    logic [fpga_pkg::PORT_CNT-1:0] exp_g;
    logic [fpga_pkg::PORT_CNT-1:0] exp_y;
} test_row_t;

logic                                            clk_125mhz;
logic                                            arst_n;
logic                                            mmcm_locked;
fpga_pkg::port_status_t [fpga_pkg::PORT_CNT-1:0] port_status;
logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_act;
logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_g;
logic [fpga_pkg::PORT_CNT-1:0]                   qsfp_led_stat_y;
logic                                            core_rst;
logic                                            test_done;
int                                              test_idx;
logic [fpga_pkg::PORT_CNT-1:0]                   exp_act;
logic [fpga_pkg::PORT_CNT-1:0]                   exp_g;
logic [fpga_pkg::PORT_CNT-1:0]                   exp_y;
int                                              pass_cnt;
int                                              fail_cnt;
int                                              limit_cycles = 0;
test_row_t                                       rows [10];

fpga dut (
    .clk_125mhz(clk_125mhz),
    .arst_n(arst_n),
    .mmcm_locked(mmcm_locked),
    .port_status(port_status),
    .qsfp_led_act(qsfp_led_act),
    .qsfp_led_stat_g(qsfp_led_stat_g),
    .qsfp_led_stat_y(qsfp_led_stat_y),
    .core_rst(core_rst)
);

fpga_checker chk (.*);

always #5 clk_125mhz = ~clk_125mhz;

task automatic load_test_table();
    // len, lock, glitch_at, link_up, fault, spacing, exp_act, exp_g, exp_y
    rows[0] = '{8'd20, 1'b0, 8'd0,  2'b11, 2'b01, 8'd3,  2'b00, 2'b00, 2'b00};
    rows[1] = '{8'd40, 1'b1, 8'd0,  2'b11, 2'b00, 8'd0,  2'b00, 2'b11, 2'b00};
    rows[2] = '{8'd40, 1'b1, 8'd10, 2'b01, 2'b10, 8'd0,  2'b00, 2'b01, 2'b10};
    rows[3] = '{8'd10, 1'b0, 8'd0,  2'b11, 2'b00, 8'd2,  2'b00, 2'b00, 2'b00};
    rows[4] = '{8'd46, 1'b1, 8'd12, 2'b01, 2'b00, 8'd0,  2'b00, 2'b01, 2'b00};
    rows[5] = '{8'd30, 1'b1, 8'd0,  2'b11, 2'b10, 8'd1,  2'b11, 2'b01, 2'b10};
    rows[6] = '{8'd40, 1'b1, 8'd0,  2'b10, 2'b00, 8'd5,  2'b11, 2'b10, 2'b00};
    rows[7] = '{8'd60, 1'b1, 8'd0,  2'b00, 2'b11, 8'd14, 2'b00, 2'b00, 2'b11};
    rows[8] = '{8'd60, 1'b1, 8'd0,  2'b11, 2'b01, 8'd30, 2'b00, 2'b10, 2'b01};
    rows[9] = '{8'd15, 1'b0, 8'd0,  2'b11, 2'b00, 8'd2,  2'b00, 2'b00, 2'b00};
endtask

task automatic apply_row(input int t);
    int                                              next_pulse [fpga_pkg::PORT_CNT];
    int                                              len;
    int                                              gap;
    int                                              pulse_stop;
    fpga_pkg::port_status_t [fpga_pkg::PORT_CNT-1:0] st;
    len = int'(rows[t].len);
    gap = int'(rows[t].spacing);
    // Wide spacing ends pulses early so act has drained by the row end
    pulse_stop = (gap > int'(fpga_pkg::ACT_HOLD_CYCLES)) ?
                 len - int'(fpga_pkg::ACT_HOLD_CYCLES) - 4 : len;
    for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
        next_pulse[p] = (gap == 0) ? len : int'($urandom % 32'(gap));
    end
    for (int c = 0; c < len; c++) begin
        @(posedge clk_125mhz);
        st = '0;
        for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
            st[p].link_up = rows[t].link_up[p];
            st[p].fault   = rows[t].fault[p];
            if (c == next_pulse[p] && c < pulse_stop) begin
                if ($urandom % 2 == 0) begin
                    st[p].rx_act = 1'b1;
                end else begin
                    st[p].tx_act = 1'b1;
                end
                next_pulse[p] = c + 1 + int'($urandom % 32'(gap));
            end
        end
        port_status <= st;
        mmcm_locked <= (rows[t].glitch_at != '0 && c == int'(rows[t].glitch_at)) ?
                       ~rows[t].lock : rows[t].lock;
        test_done   <= 1'b0;
    end
    // Closing cycle without pulses where the checker compares the end levels
    @(posedge clk_125mhz);
    for (int p = 0; p < fpga_pkg::PORT_CNT; p++) begin
        st[p].rx_act = 1'b0;
        st[p].tx_act = 1'b0;
    end
    port_status <= st;
    test_idx    <= t;
    exp_act     <= rows[t].exp_act;
    exp_g       <= rows[t].exp_g;
    exp_y       <= rows[t].exp_y;
    test_done   <= 1'b1;
endtask

initial begin
    int cycle_sum;
    clk_125mhz  = 1'b0;
    arst_n      = 1'b1;
    mmcm_locked = 1'b0;
    port_status = '0;
    test_done   = 1'b0;
    test_idx    = 0;
    exp_act     = '0;
    exp_g       = '0;
    exp_y       = '0;
    void'($urandom(7682));
    load_test_table();
    cycle_sum = 3;
    foreach (rows[t]) begin
        cycle_sum += int'(rows[t].len) + 1;
    end
    limit_cycles = cycle_sum + 200;
    // Clean falling edge for the asynchronous reset
    #1 arst_n = 1'b0;
    repeat (3) @(posedge clk_125mhz);
    arst_n <= 1'b1;
    foreach (rows[t]) begin
        apply_row(t);
    end
    @(posedge clk_125mhz);
    test_done <= 1'b0;
    repeat (2) @(posedge clk_125mhz);
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == $size(rows)) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_125mhz);
    $display("Watchdog: the run did not complete within %0d cycles", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
end

endmodule

/* verilog.f */
logic/fpga_pkg.sv
logic/cycle_timer.sv
logic/reset_supervisor.sv
logic/port_led_ctrl.sv
logic/fpga.sv
test/fpga_sva.sv
test/fpga_checker.sv
test/tb_fpga.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -j 0 \
    --top-module tb_fpga \
    -Mdir obj_dir \
    -o tb_fpga_sim \
    -f verilog.f

./obj_dir/tb_fpga_sim 2>&1 | tee "${LOG}"

if grep -q "Simulation finished: FAIL" "${LOG}"; then
    echo "Run failed, see ${LOG}"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "${LOG}"; then
    echo "Run ended without a verdict, see ${LOG}"
    exit 1
fi

echo "Run passed"
